//--- rtl/spmm_pkg.sv
package spmm_pkg;

    // matrix order and element width
    localparam int N = 8;
    localparam int W = 8;

    // rows moved per load beat and per output beat
    localparam int ROWS_PER_BEAT = 4;
    localparam int BEATS = N / ROWS_PER_BEAT;

    localparam int IDX_W = $clog2(N);
    // pointers run 0..N inclusive, so one bit more than an index
    localparam int PTR_W = IDX_W + 1;
    localparam int BEAT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

    typedef logic [W-1:0] data_t;
    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [BEAT_W-1:0] beat_t;

    // sparse lhs as it arrives on the top ports (csr-like)
    typedef struct packed {
        data_t [N-1:0] data;
        idx_t [N-1:0] col;
        ptr_t [N-1:0] row_ptr;
    } sparse_packet_t;

    // four rows of N elements, used for rhs load and result output
    typedef struct packed {
        data_t [ROWS_PER_BEAT-1:0][N-1:0] row;
    } rhs_beat_t;

    // packet after row-pointer decode, broadcast to every PE
    typedef struct packed {
        logic valid;
        data_t [N-1:0] data;
        idx_t [N-1:0] col;
        logic [N-1:0] seg_start;
        idx_t [N-1:0] row_last;
        logic [N-1:0] row_empty;
    } sparse_job_t;

    // one column of B
    typedef struct packed {
        data_t [N-1:0] elem;
    } rhs_column_t;

    // one output column, one sum per row
    typedef struct packed {
        logic valid;
        data_t [N-1:0] row_sum;
    } result_column_t;

    typedef enum logic [1:0] {
        RHS_EMPTY,
        RHS_LOAD,
        RHS_HELD
    } rhs_state_t;

    typedef enum logic [1:0] {
        DRAIN_IDLE,
        DRAIN_WAIT,
        DRAIN_FULL,
        DRAIN_SEND
    } drain_state_t;

endpackage

//--- rtl/operand_feeder.sv
module operand_feeder import spmm_pkg::*; (
    input logic clock,
    input logic reset,
    input logic rhs_start,
    input rhs_beat_t rhs_data,
    input logic lhs_start,
    input sparse_packet_t lhs_packet,
    input logic busy,
    output logic rhs_ready,
    output logic lhs_ready,
    output sparse_job_t job,
    output rhs_column_t columns [N]
);

    rhs_state_t rhs_state;
    // next beat to write while loading
    beat_t load_beat;
    // last beat written, one more cycle before B counts as held
    logic load_done;
    logic rhs_accept;
    logic lhs_accept;
    logic rhs_write;
    beat_t write_beat;
    sparse_job_t job_next;

    // no new work while a job is in flight or the drain holds a result
    // job.valid covers the cycle before busy rises
    assign rhs_ready = (rhs_state != RHS_LOAD) && !busy && !job.valid;
    assign lhs_ready = (rhs_state == RHS_HELD) && !busy && !job.valid;

    assign rhs_accept = rhs_start && rhs_ready;
    // a load on the same edge wins, B must not change under a live job
    assign lhs_accept = lhs_start && lhs_ready && !rhs_accept;

    // beat 0 comes with the start edge, the rest follow back to back
    assign rhs_write = rhs_accept || ((rhs_state == RHS_LOAD) && !load_done);
    assign write_beat = rhs_accept ? beat_t'(0) : load_beat;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rhs_state <= RHS_EMPTY;
            load_beat <= '0;
            load_done <= 1'b0;
        end else begin
            case (rhs_state)
                RHS_EMPTY, RHS_HELD: begin
                    if (rhs_accept) begin
                        rhs_state <= RHS_LOAD;
                        load_beat <= beat_t'(1);
                        // single-beat matrix is complete on the start edge
                        load_done <= (BEATS == 1);
                    end
                end
                RHS_LOAD: begin
                    if (load_done) begin
                        rhs_state <= RHS_HELD;
                        load_done <= 1'b0;
                    end else begin
                        load_beat <= load_beat + beat_t'(1);
                        if (load_beat == beat_t'(BEATS - 1)) begin
                            load_done <= 1'b1;
                        end
                    end
                end
                default: begin
                    rhs_state <= RHS_EMPTY;
                end
            endcase
        end
    end

    // B store, kept column-wise so each PE gets its column directly
    always_ff @(posedge clock) begin
        if (rhs_write) begin
            for (int r = 0; r < ROWS_PER_BEAT; r++) begin
                for (int c = 0; c < N; c++) begin
                    columns[c].elem[ROWS_PER_BEAT * write_beat + r] <= rhs_data.row[r][c];
                end
            end
        end
    end

    // row-pointer decode, done here once instead of in every PE
    always_comb begin
        ptr_t prev_ptr;
        prev_ptr = '0;
        job_next = '0;
        job_next.valid = 1'b1;
        job_next.data = lhs_packet.data;
        job_next.col = lhs_packet.col;
        for (int r = 0; r < N; r++) begin
            // row r+1 starts where row r ends
            if (lhs_packet.row_ptr[r] < ptr_t'(N)) begin
                job_next.seg_start[idx_t'(lhs_packet.row_ptr[r])] = 1'b1;
            end
            // wraps for an empty leading row, masked by row_empty
            job_next.row_last[r] = idx_t'(lhs_packet.row_ptr[r] - ptr_t'(1));
            job_next.row_empty[r] = (lhs_packet.row_ptr[r] == prev_ptr);
            prev_ptr = lhs_packet.row_ptr[r];
        end
    end

    // job valid is a one-cycle strobe, payload held until the next job
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            job <= '0;
        end else if (lhs_accept) begin
            job <= job_next;
        end else begin
            job.valid <= 1'b0;
        end
    end

endmodule

//--- rtl/spmm_pe.sv
module spmm_pe import spmm_pkg::*; (
    input logic clock,
    input logic reset,
    input sparse_job_t job,
    input rhs_column_t column,
    output result_column_t result
);

    data_t [N-1:0] prod_next;

    // stage 1, products plus segment info
    logic s1_valid;
    data_t [N-1:0] s1_prod;
    logic [N-1:0] s1_seg_start;
    idx_t [N-1:0] s1_row_last;
    logic [N-1:0] s1_row_empty;

    // segmented prefix over stage 1 products
    data_t [N-1:0] running;

    // stage 2, per-row sums
    logic s2_valid;
    data_t [N-1:0] s2_sum;

    // each nonzero picks B[col[k]] from this column
    // product kept mod 2^W
    always_comb begin
        for (int k = 0; k < N; k++) begin
            prod_next[k] = data_t'(job.data[k] * column.elem[job.col[k]]);
        end
    end

    // valid bits walk down the pipe
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= job.valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (job.valid) begin
            s1_prod <= prod_next;
            s1_seg_start <= job.seg_start;
            s1_row_last <= job.row_last;
            s1_row_empty <= job.row_empty;
        end
    end

    // running sum, restarts at every segment start
    // element 0 always starts a segment
    always_comb begin
        running[0] = s1_prod[0];
        for (int k = 1; k < N; k++) begin
            if (s1_seg_start[k]) begin
                running[k] = s1_prod[k];
            end else begin
                running[k] = running[k-1] + s1_prod[k];
            end
        end
    end

    // pick the sum at each row's last nonzero
    always_ff @(posedge clock) begin
        if (s1_valid) begin
            for (int r = 0; r < N; r++) begin
                if (s1_row_empty[r]) begin
                    s2_sum[r] <= '0;
                end else begin
                    s2_sum[r] <= running[s1_row_last[r]];
                end
            end
        end
    end

    assign result.valid = s2_valid;
    assign result.row_sum = s2_sum;

endmodule

//--- rtl/result_drain.sv
module result_drain import spmm_pkg::*; (
    input logic clock,
    input logic reset,
    input result_column_t results [N],
    input logic job_accept,
    input logic out_start,
    output logic busy,
    output logic out_ready,
    output logic out_valid,
    output beat_t out_beat,
    output rhs_beat_t out_data
);

    drain_state_t drain_state;
    // beat currently on the output
    beat_t send_beat;
    // row-major copy of the result, [row][col]
    data_t [N-1:0][N-1:0] result_buf;
    logic capture;

    // all PEs share timing, column 0 speaks for the array
    assign capture = (drain_state == DRAIN_WAIT) && results[0].valid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            drain_state <= DRAIN_IDLE;
            send_beat <= '0;
        end else begin
            case (drain_state)
                DRAIN_IDLE: begin
                    // claim the drain as soon as the feeder takes a job
                    if (job_accept) begin
                        drain_state <= DRAIN_WAIT;
                    end
                end
                DRAIN_WAIT: begin
                    if (capture) begin
                        drain_state <= DRAIN_FULL;
                    end
                end
                DRAIN_FULL: begin
                    if (out_start) begin
                        drain_state <= DRAIN_SEND;
                        send_beat <= '0;
                    end
                end
                DRAIN_SEND: begin
                    if (send_beat == beat_t'(BEATS - 1)) begin
                        drain_state <= DRAIN_IDLE;
                    end else begin
                        send_beat <= send_beat + beat_t'(1);
                    end
                end
                default: begin
                    drain_state <= DRAIN_IDLE;
                end
            endcase
        end
    end

    // transpose columns into rows on capture
    always_ff @(posedge clock) begin
        if (capture) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N; c++) begin
                    result_buf[r][c] <= results[c].row_sum[r];
                end
            end
        end
    end

    assign busy = (drain_state != DRAIN_IDLE);
    assign out_ready = (drain_state == DRAIN_FULL);
    assign out_valid = (drain_state == DRAIN_SEND);
    assign out_beat = send_beat;

    // rows 4*beat .. 4*beat+3
    always_comb begin
        for (int i = 0; i < ROWS_PER_BEAT; i++) begin
            out_data.row[i] = result_buf[ROWS_PER_BEAT * send_beat + i];
        end
    end

endmodule

//--- rtl/spmm_top.sv
module spmm_top import spmm_pkg::*; (
    input logic clock,
    input logic reset,
    input logic rhs_start,
    input rhs_beat_t rhs_data,
    output logic rhs_ready,
    input logic lhs_start,
    input sparse_packet_t lhs_packet,
    output logic lhs_ready,
    input logic out_start,
    output logic out_ready,
    output logic out_valid,
    output beat_t out_beat,
    output rhs_beat_t out_data
);

    // decoded job, same for every PE
    sparse_job_t job;
    // column j of B goes to PE j
    rhs_column_t columns [N];
    result_column_t results [N];
    // drain holds the array from job accept until the last beat
    logic busy;

    operand_feeder u_feeder (
        .clock      (clock),
        .reset      (reset),
        .rhs_start  (rhs_start),
        .rhs_data   (rhs_data),
        .lhs_start  (lhs_start),
        .lhs_packet (lhs_packet),
        .busy       (busy),
        .rhs_ready  (rhs_ready),
        .lhs_ready  (lhs_ready),
        .job        (job),
        .columns    (columns)
    );

    // one PE per output column
    for (genvar j = 0; j < N; j++) begin : gen_pe
        spmm_pe u_pe (
            .clock  (clock),
            .reset  (reset),
            .job    (job),
            .column (columns[j]),
            .result (results[j])
        );
    end

    result_drain u_drain (
        .clock      (clock),
        .reset      (reset),
        .results    (results),
        .job_accept (job.valid),
        .out_start  (out_start),
        .busy       (busy),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_data   (out_data)
    );

endmodule

//--- test/spmm_assertions.sv
module spmm_assertions import spmm_pkg::*; (
    input logic clock,
    input logic reset,
    input logic out_start,
    input logic out_ready,
    input logic out_valid,
    input beat_t out_beat
);

    // a taken out_start ends the offer and the burst follows at once
    assert property (@(posedge clock) disable iff (reset)
        (out_ready && out_start) |=> (out_valid && !out_ready))
        else $error("out_start was taken but out_ready stayed up or out_valid did not rise");

    // one burst is exactly BEATS cycles long
    assert property (@(posedge clock) disable iff (reset)
        $rose(out_valid) |-> out_valid [*BEATS] ##1 !out_valid)
        else $error("out_valid burst length differs from BEATS");

    // burst opens with beat 0
    assert property (@(posedge clock) disable iff (reset)
        $rose(out_valid) |-> (out_beat == beat_t'(0)))
        else $error("first out_beat of a burst is not 0");

    // beat number steps by one inside a burst
    assert property (@(posedge clock) disable iff (reset)
        out_valid ##1 out_valid |-> (out_beat == beat_t'($past(out_beat) + 1)))
        else $error("out_beat did not increment by one");

endmodule

bind result_drain spmm_assertions u_assertions (
    .clock     (clock),
    .reset     (reset),
    .out_start (out_start),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat)
);

//--- test/spmm_tb.sv
module spmm_tb import spmm_pkg::*; ();

    // cycles any single wait may take
    localparam int WAIT_LIMIT = 50;

    logic clock = 1'b0;
    logic reset;
    logic rhs_start;
    rhs_beat_t rhs_data;
    logic rhs_ready;
    logic lhs_start;
    sparse_packet_t lhs_packet;
    logic lhs_ready;
    logic out_start;
    logic out_ready;
    logic out_valid;
    beat_t out_beat;
    rhs_beat_t out_data;

    int seed;
    int errors = 0;
    int timeouts = 0;
    // B as [row][col], expected and received results as [row][col]
    data_t b_mat [N][N];
    data_t exp_mat [N][N];
    data_t got [N][N];

    spmm_top UUT (
        .clock      (clock),
        .reset      (reset),
        .rhs_start  (rhs_start),
        .rhs_data   (rhs_data),
        .rhs_ready  (rhs_ready),
        .lhs_start  (lhs_start),
        .lhs_packet (lhs_packet),
        .lhs_ready  (lhs_ready),
        .out_start  (out_start),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_data   (out_data)
    );

    always #4 clock = ~clock;

    task automatic end_run();
        $display("value errors: %0d, timeouts: %0d", errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        timeouts++;
        end_run();
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s: expected %0b, actual %0b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_beat(input string name, input beat_t expected, input beat_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("error %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // reference: sum of data[k]*B[col[k]][j] over row r, mod 256
    task automatic compute_expected(input sparse_packet_t p);
        int first;
        int last;
        data_t acc;
        first = 0;
        for (int r = 0; r < N; r++) begin
            last = int'(p.row_ptr[r]);
            for (int j = 0; j < N; j++) begin
                acc = '0;
                for (int k = first; k < last; k++) begin
                    acc = acc + p.data[k] * b_mat[p.col[k]][j];
                end
                exp_mat[r][j] = acc;
            end
            first = last;
        end
    endtask

    // nonzeros per row given by counts, values and columns random
    task automatic build_packet(output sparse_packet_t p, input int counts [N]);
        int acc;
        acc = 0;
        for (int r = 0; r < N; r++) begin
            acc += counts[r];
            p.row_ptr[r] = ptr_t'(acc);
            p.data[r] = data_t'($random(seed));
            p.col[r] = idx_t'($random(seed));
        end
    endtask

    task automatic randomize_b();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                b_mat[r][c] = data_t'($random(seed));
            end
        end
    endtask

    task automatic load_rhs();
        int waited;
        rhs_beat_t beat;
        waited = 0;
        @(negedge clock);
        while (!rhs_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) timeout_fail("rhs_ready never rose");
            @(negedge clock);
        end
        // beat 0 goes with the start pulse, the others on following edges
        for (int b = 0; b < BEATS; b++) begin
            for (int i = 0; i < ROWS_PER_BEAT; i++) begin
                for (int c = 0; c < N; c++) begin
                    beat.row[i][c] = b_mat[ROWS_PER_BEAT * b + i][c];
                end
            end
            @(posedge clock);
            rhs_start <= (b == 0);
            rhs_data <= beat;
        end
        @(posedge clock);
        rhs_start <= 1'b0;
        rhs_data <= '0;
    endtask

    // returns cycles from the accept edge until out_ready
    task automatic send_packet(input sparse_packet_t p, output int latency);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!lhs_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) timeout_fail("lhs_ready never rose");
            @(negedge clock);
        end
        @(posedge clock);
        lhs_start <= 1'b1;
        lhs_packet <= p;
        // accept edge
        @(posedge clock);
        lhs_start <= 1'b0;
        latency = 0;
        @(negedge clock);
        check_flag("lhs_ready after accept", 1'b0, lhs_ready);
        check_flag("rhs_ready after accept", 1'b0, rhs_ready);
        while (!out_ready) begin
            latency++;
            if (latency > WAIT_LIMIT) timeout_fail("out_ready never rose after lhs_start");
            @(negedge clock);
        end
    endtask

    task automatic drain_result(input string name);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!out_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) timeout_fail("out_ready never rose");
            @(negedge clock);
        end
        @(posedge clock);
        out_start <= 1'b1;
        @(posedge clock);
        out_start <= 1'b0;
        waited = 0;
        @(negedge clock);
        while (!out_valid) begin
            waited++;
            if (waited > WAIT_LIMIT) timeout_fail("out_valid never rose after out_start");
            @(negedge clock);
        end
        for (int b = 0; b < BEATS; b++) begin
            if (b > 0) begin
                @(negedge clock);
                check_flag({name, " out_valid"}, 1'b1, out_valid);
            end
            // the offer is withdrawn once sending starts
            check_flag({name, " out_ready during burst"}, 1'b0, out_ready);
            check_beat({name, " out_beat"}, beat_t'(b), out_beat);
            for (int i = 0; i < ROWS_PER_BEAT; i++) begin
                for (int c = 0; c < N; c++) begin
                    got[ROWS_PER_BEAT * b + i][c] = out_data.row[i][c];
                end
            end
        end
        @(negedge clock);
        check_flag({name, " out_valid after burst"}, 1'b0, out_valid);
    endtask

    task automatic compare_result(input string name);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                check_data($sformatf("%s row %0d col %0d", name, r, c), exp_mat[r][c], got[r][c]);
            end
        end
    endtask

    task automatic reset_defaults();
        @(negedge clock);
        check_flag("reset rhs_ready", 1'b1, rhs_ready);
        check_flag("reset lhs_ready", 1'b0, lhs_ready);
        check_flag("reset out_ready", 1'b0, out_ready);
        check_flag("reset out_valid", 1'b0, out_valid);
    endtask

    task automatic identity_job();
        sparse_packet_t p;
        int latency;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                b_mat[r][c] = (r == c) ? data_t'(1) : data_t'(0);
            end
        end
        load_rhs();
        // one nonzero per row, columns permuted
        for (int k = 0; k < N; k++) begin
            p.data[k] = data_t'($random(seed)) | data_t'(1);
            p.col[k] = idx_t'((3 * k + 1) % N);
            p.row_ptr[k] = ptr_t'(k + 1);
        end
        send_packet(p, latency);
        check_count("identity latency", 3, latency);
        drain_result("identity");
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                exp_mat[r][c] = (idx_t'(c) == p.col[r]) ? p.data[r] : data_t'(0);
            end
        end
        compare_result("identity");
    endtask

    task automatic random_job();
        sparse_packet_t p;
        int latency;
        randomize_b();
        load_rhs();
        // empty first row, a three-term row, several empty rows
        build_packet(p, '{0, 3, 1, 0, 2, 0, 1, 1});
        compute_expected(p);
        send_packet(p, latency);
        check_count("random latency", 3, latency);
        drain_result("random");
        compare_result("random");
    endtask

    // two jobs against one load
    task automatic rhs_reuse();
        sparse_packet_t p;
        int latency;
        randomize_b();
        load_rhs();
        build_packet(p, '{2, 0, 0, 2, 1, 0, 0, 3});
        compute_expected(p);
        send_packet(p, latency);
        drain_result("reuse first");
        compare_result("reuse first");
        // whole packet in the last row
        build_packet(p, '{0, 0, 0, 0, 0, 0, 0, 8});
        compute_expected(p);
        send_packet(p, latency);
        drain_result("reuse second");
        compare_result("reuse second");
    endtask

    task automatic ignored_starts();
        sparse_packet_t p;
        sparse_packet_t other;
        rhs_beat_t junk;
        int latency;
        build_packet(p, '{1, 2, 0, 1, 1, 0, 2, 1});
        build_packet(other, '{8, 0, 0, 0, 0, 0, 0, 0});
        for (int i = 0; i < ROWS_PER_BEAT; i++) begin
            for (int c = 0; c < N; c++) begin
                junk.row[i][c] = data_t'($random(seed));
            end
        end
        compute_expected(p);
        send_packet(p, latency);
        // result waits, both starts held for two edges
        @(posedge clock);
        lhs_start <= 1'b1;
        lhs_packet <= other;
        rhs_start <= 1'b1;
        rhs_data <= junk;
        repeat (2) begin
            @(negedge clock);
            check_flag("ignored lhs_ready", 1'b0, lhs_ready);
            check_flag("ignored rhs_ready", 1'b0, rhs_ready);
            check_flag("ignored out_ready", 1'b1, out_ready);
        end
        @(posedge clock);
        lhs_start <= 1'b0;
        rhs_start <= 1'b0;
        rhs_data <= '0;
        drain_result("ignored starts");
        compare_result("ignored starts");
        // B must be untouched by the dropped load
        send_packet(p, latency);
        drain_result("ignored starts rerun");
        compare_result("ignored starts rerun");
    endtask

    initial begin
        seed = 46911;
        reset = 1'b1;
        rhs_start = 1'b0;
        rhs_data = '0;
        lhs_start = 1'b0;
        lhs_packet = '0;
        out_start = 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        reset_defaults();
        identity_job();
        random_job();
        rhs_reuse();
        ignored_starts();
        end_run();
    end

endmodule

//--- compile.f
rtl/spmm_pkg.sv
rtl/operand_feeder.sv
rtl/spmm_pe.sv
rtl/result_drain.sv
rtl/spmm_top.sv
test/spmm_assertions.sv
test/spmm_tb.sv

//--- Bender.yml
package:
  name: spmm

sources:
  - rtl/spmm_pkg.sv
  - rtl/operand_feeder.sv
  - rtl/spmm_pe.sv
  - rtl/result_drain.sv
  - rtl/spmm_top.sv
  - target: test
    files:
      - test/spmm_assertions.sv
      - test/spmm_tb.sv
